//--- rtl/id_stage.sv
`timescale 1ns/10ps

module id_stage import rv_decode_pkg::*;
(
	input	logic		clk_i,
	input	logic		rst_n_i,
	// fetch side
	input	logic		if_valid_i,
	output	logic		if_ready_o,
	input	word_t		if_pc_i,
	input	word_t		if_insn_i,
	// external regfile
	output	reg_addr_t	gpr_rd_addr_0_o,
	output	reg_addr_t	gpr_rd_addr_1_o,
	input	word_t		gpr_rd_data_0_i,
	input	word_t		gpr_rd_data_1_i,
	// bypass from later stages
	input	word_t		exe_fwd_data_i,
	input	logic		mem_stage_valid_i,
	input	reg_addr_t	mem_stage_dst_i,
	input	logic		mem_stage_we_i,
	input	word_t		mem_fwd_data_i,
	// execute side
	output	logic		id_valid_o,
	input	logic		id_ready_i,
	output	alu_op_e	alu_op_o,
	output	word_t		alu_in_0_o,
	output	word_t		alu_in_1_o,
	output	word_t		br_addr_o,
	output	logic		br_taken_o,
	output	logic		br_flag_o,
	output	mem_op_e	mem_op_o,
	output	word_t		mem_wr_data_o,
	output	reg_addr_t	dst_addr_o,
	output	logic		gpr_we_o
);

	operand_if	op_if ();			// decoder <-> forwarding

	id_result_t	dec_result;			// combinational decode
	id_result_t	held;				// registered, in execute

	//////////////////////////////
	insn_decoder i_insn_decoder
	(
		.op					(op_if),
		.insn_i				(if_insn_i),
		.pc_i				(if_pc_i),
		.result_o			(dec_result)
	);

	operand_fwd i_operand_fwd
	(
		.op					(op_if),
		.gpr_rd_data_0_i	(gpr_rd_data_0_i),
		.gpr_rd_data_1_i	(gpr_rd_data_1_i),
		.exe_fwd_data_i		(exe_fwd_data_i),
		.mem_stage_valid_i	(mem_stage_valid_i),
		.mem_stage_dst_i	(mem_stage_dst_i),
		.mem_stage_we_i		(mem_stage_we_i),
		.mem_fwd_data_i		(mem_fwd_data_i),
		.held_valid_i		(id_valid_o),
		.held_i				(held)
	);

	id_stage_reg i_id_stage_reg
	(
		.clk_i				(clk_i),
		.rst_n_i			(rst_n_i),
		.in_valid_i			(if_valid_i),
		.in_i				(dec_result),
		.stall_i			(op_if.ld_hazard),
		.out_ready_i		(id_ready_i),
		.in_ready_o			(if_ready_o),
		.out_valid_o		(id_valid_o),
		.out_o				(held)
	);

	//////////////////////////////
	assign gpr_rd_addr_0_o	= op_if.rs1;		// zero-cycle regfile address
	assign gpr_rd_addr_1_o	= op_if.rs2;
	assign alu_op_o			= held.alu_op;
	assign alu_in_0_o		= held.alu_in_0;
	assign alu_in_1_o		= held.alu_in_1;
	assign br_addr_o		= held.br_addr;
	assign br_taken_o		= held.br_taken;
	assign br_flag_o		= held.br_flag;
	assign mem_op_o			= held.mem_op;
	assign mem_wr_data_o	= held.mem_wr_data;
	assign dst_addr_o		= held.dst_addr;
	assign gpr_we_o			= held.gpr_we;

endmodule

//--- rtl/id_stage_reg.sv
`timescale 1ns/10ps

module id_stage_reg import rv_decode_pkg::*;
(
	input	logic		clk_i,
	input	logic		rst_n_i,
	input	logic		in_valid_i,		// decoder side
	input	id_result_t	in_i,
	input	logic		stall_i,		// load-use hazard
	input	logic		out_ready_i,	// execute side
	output	logic		in_ready_o,
	output	logic		out_valid_o,
	output	id_result_t	out_o
);

	logic	load;			// transfer into the register

	//////////////////////////////
	// accept when empty or draining, never across a hazard
	assign in_ready_o	= (!out_valid_o || out_ready_i) && !stall_i;
	assign load			= in_valid_i && in_ready_o;

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
			out_valid_o <= 1'b0;
		else if (load)
			out_valid_o <= 1'b1;			// refill or fresh load
		else if (out_ready_i)
			out_valid_o <= 1'b0;			// drained, nothing behind
	end

	always_ff @(posedge clk_i)
	begin
		if (load)
			out_o <= in_i;					// payload only moves on a transfer
	end

	//////////////////////////////
	// a stalled result stays put and stays valid until taken
	hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_o)));

endmodule

//--- rtl/insn_decoder.sv
`timescale 1ns/10ps
`include "rv_decode_params.svh"

module insn_decoder import rv_decode_pkg::*;
(
	operand_if.dec		op,			// rs addresses out, operands back
	input	word_t		insn_i,
	input	word_t		pc_i,
	output	id_result_t	result_o
);

	logic	[6:0]	opcode;
	logic	[2:0]	funct3;
	logic	[6:0]	funct7;
	reg_addr_t		rd;
	word_t			imm_i;
	word_t			imm_s;
	word_t			imm_b;
	word_t			imm_u;
	word_t			imm_j;
	word_t			shamt;
	word_t			ra;
	word_t			rb;
	word_t			ret_addr;
	word_t			br_target;
	word_t			jal_target;
	word_t			jalr_target;
	logic			s_lt_rb;
	logic			u_lt_rb;
	logic			s_lt_imm;
	logic			u_lt_imm;

	//////////////////////////////
	// field split
	assign opcode	= insn_i[6:0];
	assign rd		= insn_i[11:7];
	assign funct3	= insn_i[14:12];
	assign funct7	= insn_i[31:25];
	assign op.rs1	= insn_i[19:15];	// regfile read addr follows insn directly
	assign op.rs2	= insn_i[24:20];
	assign ra		= op.ra_data;		// already forwarded
	assign rb		= op.rb_data;

	// immediates, all sign extended from insn[31]
	assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
	assign imm_s = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
	assign imm_b = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
	assign imm_u = {insn_i[31:12], 12'b0};
	assign imm_j = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};
	assign shamt = {{(`XLEN-5){1'b0}}, insn_i[24:20]};	// shift amount for slli/srli/srai

	//////////////////////////////
	// addresses and compares
	assign ret_addr		= pc_i + `PC_STEP;			// link value
	assign br_target	= pc_i + imm_b;
	assign jal_target	= pc_i + imm_j;
	assign jalr_target	= (ra + imm_i) & ~word_t'(1);	// lsb cleared per isa
	assign s_lt_rb		= $signed(ra) < $signed(rb);
	assign u_lt_rb		= ra < rb;
	assign s_lt_imm		= $signed(ra) < $signed(imm_i);
	assign u_lt_imm		= ra < imm_i;				// sltiu compares sext imm unsigned

	//////////////////////////////
	always_comb
	begin
		result_o.alu_op			= ALU_NOP;		// no-op defaults
		result_o.alu_in_0		= ra;
		result_o.alu_in_1		= rb;
		result_o.br_addr		= '0;
		result_o.br_taken		= 1'b0;
		result_o.br_flag		= 1'b0;
		result_o.mem_op			= MEM_NOP;
		result_o.mem_wr_data	= '0;
		result_o.dst_addr		= rd;
		result_o.gpr_we			= 1'b0;

		case (opcode)
			`OPC_LUI:
			begin
				result_o.alu_op		= ALU_PASS;
				result_o.alu_in_0	= '0;
				result_o.alu_in_1	= imm_u;
				result_o.gpr_we		= 1'b1;
			end
			`OPC_AUIPC:
			begin
				result_o.alu_op		= ALU_ADD;
				result_o.alu_in_0	= pc_i;		// pc relative
				result_o.alu_in_1	= imm_u;
				result_o.gpr_we		= 1'b1;
			end
			`OPC_JAL, `OPC_JALR:
			begin
				result_o.alu_op		= ALU_PASS;
				result_o.alu_in_1	= ret_addr;	// rd gets pc+4
				result_o.br_addr	= (opcode == `OPC_JAL) ? jal_target : jalr_target;
				result_o.br_taken	= 1'b1;
				result_o.br_flag	= 1'b1;
				result_o.gpr_we		= 1'b1;
			end
			`OPC_BRANCH:
			begin
				result_o.br_flag	= 1'b1;
				result_o.br_addr	= br_target;
				case (funct3)
					`F3_BEQ:	result_o.br_taken = (ra == rb);
					`F3_BNE:	result_o.br_taken = (ra != rb);
					`F3_BLT:	result_o.br_taken = s_lt_rb;
					`F3_BGE:	result_o.br_taken = !s_lt_rb;
					`F3_BLTU:	result_o.br_taken = u_lt_rb;
					`F3_BGEU:	result_o.br_taken = !u_lt_rb;
					default:
					begin
						result_o.br_flag	= 1'b0;		// undefined funct3 flows as nop
						result_o.br_addr	= '0;
					end
				endcase
			end
			`OPC_LOAD:
			begin
				case (funct3)
					`F3_LB:		result_o.mem_op = MEM_LB;
					`F3_LH:		result_o.mem_op = MEM_LH;
					`F3_LW:		result_o.mem_op = MEM_LW;
					`F3_LBU:	result_o.mem_op = MEM_LBU;
					`F3_LHU:	result_o.mem_op = MEM_LHU;
					default:	result_o.mem_op = MEM_NOP;
				endcase
				if (result_o.mem_op != MEM_NOP)
				begin
					result_o.alu_op		= ALU_ADD;	// base + offset
					result_o.alu_in_1	= imm_i;
					result_o.gpr_we		= 1'b1;
				end
			end
			`OPC_STORE:
			begin
				case (funct3)
					`F3_SB:		result_o.mem_op = MEM_SB;
					`F3_SH:		result_o.mem_op = MEM_SH;
					`F3_SW:		result_o.mem_op = MEM_SW;
					default:	result_o.mem_op = MEM_NOP;
				endcase
				if (result_o.mem_op != MEM_NOP)
				begin
					result_o.alu_op			= ALU_ADD;
					result_o.alu_in_1		= imm_s;
					result_o.mem_wr_data	= rb;	// no gpr write
				end
			end
			`OPC_OP_IMM:
			begin
				result_o.alu_in_1	= imm_i;
				result_o.gpr_we		= 1'b1;
				case (funct3)
					`F3_ADD:	result_o.alu_op = ALU_ADD;	// no subi in isa
					`F3_XOR:	result_o.alu_op = ALU_XOR;
					`F3_OR:		result_o.alu_op = ALU_OR;
					`F3_AND:	result_o.alu_op = ALU_AND;
					`F3_SLT:
					begin
						result_o.alu_op		= ALU_PASS;
						result_o.alu_in_1	= word_t'(s_lt_imm);
					end
					`F3_SLTU:
					begin
						result_o.alu_op		= ALU_PASS;
						result_o.alu_in_1	= word_t'(u_lt_imm);
					end
					`F3_SLL:
					begin
						result_o.alu_op		= ALU_SLL;
						result_o.alu_in_1	= shamt;
					end
					`F3_SR:
					begin
						result_o.alu_op		= (funct7 == `F7_ALT) ? ALU_SRA : ALU_SRL;
						result_o.alu_in_1	= shamt;
					end
				endcase
			end
			`OPC_OP:
			begin
				result_o.gpr_we = 1'b1;
				case (funct3)
					`F3_ADD:	result_o.alu_op = (funct7 == `F7_ALT) ? ALU_SUB : ALU_ADD;
					`F3_SLL:	result_o.alu_op = ALU_SLL;
					`F3_XOR:	result_o.alu_op = ALU_XOR;
					`F3_SR:		result_o.alu_op = (funct7 == `F7_ALT) ? ALU_SRA : ALU_SRL;
					`F3_OR:		result_o.alu_op = ALU_OR;
					`F3_AND:	result_o.alu_op = ALU_AND;
					`F3_SLT:
					begin
						result_o.alu_op		= ALU_PASS;
						result_o.alu_in_1	= word_t'(s_lt_rb);
					end
					`F3_SLTU:
					begin
						result_o.alu_op		= ALU_PASS;
						result_o.alu_in_1	= word_t'(u_lt_rb);
					end
				endcase
			end
			default:
			begin
				result_o.gpr_we = 1'b0;		// system, fence and unknown pass as nop
			end
		endcase
	end

endmodule

//--- rtl/operand_fwd.sv
`timescale 1ns/10ps

module operand_fwd import rv_decode_pkg::*;
(
	operand_if.fwd		op,					// rs addresses in, operands out
	input	word_t		gpr_rd_data_0_i,	// regfile port 0
	input	word_t		gpr_rd_data_1_i,	// regfile port 1
	input	word_t		exe_fwd_data_i,		// alu result of insn in execute
	input	logic		mem_stage_valid_i,
	input	reg_addr_t	mem_stage_dst_i,
	input	logic		mem_stage_we_i,
	input	word_t		mem_fwd_data_i,		// result leaving mem stage
	input	logic		held_valid_i,		// stage register holds an insn
	input	id_result_t	held_i				// insn now in execute
);

	logic	exe_wr;			// execute insn will write a gpr
	logic	mem_wr;			// mem stage insn will write a gpr
	logic	exe_hit_0;
	logic	exe_hit_1;
	logic	mem_hit_0;
	logic	mem_hit_1;

	//////////////////////////////
	// writer qualification
	assign exe_wr = held_valid_i && held_i.gpr_we;
	assign mem_wr = mem_stage_valid_i && mem_stage_we_i;

	assign exe_hit_0 = exe_wr && (held_i.dst_addr == op.rs1);	// youngest writer first
	assign exe_hit_1 = exe_wr && (held_i.dst_addr == op.rs2);
	assign mem_hit_0 = mem_wr && (mem_stage_dst_i == op.rs1);
	assign mem_hit_1 = mem_wr && (mem_stage_dst_i == op.rs2);

	//////////////////////////////
	// operand muxes
	always_comb
	begin
		if (exe_hit_0)
			op.ra_data = exe_fwd_data_i;		// from execute
		else if (mem_hit_0)
			op.ra_data = mem_fwd_data_i;		// from mem stage
		else
			op.ra_data = gpr_rd_data_0_i;		// regfile
	end

	always_comb
	begin
		if (exe_hit_1)
			op.rb_data = exe_fwd_data_i;
		else if (mem_hit_1)
			op.rb_data = mem_fwd_data_i;
		else
			op.rb_data = gpr_rd_data_1_i;
	end

	//////////////////////////////
	// load data not ready until mem stage, so stall one slot
	assign op.ld_hazard = held_valid_i && is_load(held_i.mem_op) &&
		((held_i.dst_addr == op.rs1) || (held_i.dst_addr == op.rs2));

	// a hazard always points at a live load that the decoder marked as a writer
	always_comb
	begin
		hazard_on_writer: assert (!op.ld_hazard || (held_valid_i && held_i.gpr_we));
	end

endmodule

//--- rtl/operand_if.sv
`timescale 1ns/10ps

interface operand_if import rv_decode_pkg::*;
();
	reg_addr_t	rs1;			// source addresses from decoder
	reg_addr_t	rs2;
	word_t		ra_data;		// resolved operand a
	word_t		rb_data;		// resolved operand b
	logic		ld_hazard;		// dependent on load in execute

	modport dec
	(
		output	rs1,
		output	rs2,
		input	ra_data,
		input	rb_data
	);

	modport fwd
	(
		input	rs1,
		input	rs2,
		output	ra_data,
		output	rb_data,
		output	ld_hazard
	);

endinterface

//--- rtl/rv_decode_params.svh
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

//////////////////////////////
`define XLEN		32			// data and address width
`define REG_AW		5			// gpr address width
`define PC_STEP		32'd4		// byte step to next insn

//////////////////////////////
`define OPC_LUI		7'b0110111	// major opcodes in insn[6:0]
`define OPC_AUIPC	7'b0010111
`define OPC_JAL		7'b1101111
`define OPC_JALR	7'b1100111
`define OPC_BRANCH	7'b1100011
`define OPC_LOAD	7'b0000011
`define OPC_STORE	7'b0100011
`define OPC_OP_IMM	7'b0010011
`define OPC_OP		7'b0110011

//////////////////////////////
`define F3_BEQ		3'b000		// conditional branches
`define F3_BNE		3'b001
`define F3_BLT		3'b100
`define F3_BGE		3'b101
`define F3_BLTU		3'b110
`define F3_BGEU		3'b111
`define F3_LB		3'b000		// loads
`define F3_LH		3'b001
`define F3_LW		3'b010
`define F3_LBU		3'b100
`define F3_LHU		3'b101
`define F3_SB		3'b000		// stores
`define F3_SH		3'b001
`define F3_SW		3'b010
`define F3_ADD		3'b000		// alu group, shared by op and op_imm
`define F3_SLL		3'b001
`define F3_SLT		3'b010
`define F3_SLTU		3'b011
`define F3_XOR		3'b100
`define F3_SR		3'b101		// srl or sra
`define F3_OR		3'b110
`define F3_AND		3'b111

`define F7_ALT		7'b0100000	// selects sub and sra

`endif

//--- rtl/rv_decode_pkg.sv
package rv_decode_pkg;

`include "rv_decode_params.svh"

	typedef logic [`XLEN-1:0]	word_t;			// data word and byte address
	typedef logic [`REG_AW-1:0]	reg_addr_t;		// gpr index

	//////////////////////////////
	typedef enum logic [3:0]
	{
		ALU_NOP		= 4'd0,
		ALU_ADD		= 4'd1,
		ALU_SUB		= 4'd2,
		ALU_AND		= 4'd3,
		ALU_OR		= 4'd4,
		ALU_XOR		= 4'd5,
		ALU_SLL		= 4'd6,
		ALU_SRL		= 4'd7,
		ALU_SRA		= 4'd8,
		ALU_PASS	= 4'd9		// result is alu_in_1
	} alu_op_e;

	typedef enum logic [3:0]
	{
		MEM_NOP		= 4'd0,
		MEM_LB		= 4'd1,
		MEM_LH		= 4'd2,
		MEM_LW		= 4'd3,
		MEM_LBU		= 4'd4,
		MEM_LHU		= 4'd5,
		MEM_SB		= 4'd6,
		MEM_SH		= 4'd7,
		MEM_SW		= 4'd8
	} mem_op_e;

	//////////////////////////////
	typedef struct packed
	{
		alu_op_e	alu_op;
		word_t		alu_in_0;		// rs1 side
		word_t		alu_in_1;		// rs2 or immediate side
		word_t		br_addr;		// jump or branch target
		logic		br_taken;
		logic		br_flag;		// insn is a control transfer
		mem_op_e	mem_op;
		word_t		mem_wr_data;	// store data
		reg_addr_t	dst_addr;		// always rd
		logic		gpr_we;			// active high
	} id_result_t;

	function automatic logic is_load(input mem_op_e op);
		return (op == MEM_LB) || (op == MEM_LH) || (op == MEM_LW) ||
			(op == MEM_LBU) || (op == MEM_LHU);
	endfunction

endpackage

//--- run_sim.sh
#!/bin/sh
# builds the decode stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f rv_decode.f --top-module tb_id_stage \
	--Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported failure, see sim.log"
	exit 1
fi

echo "simulation clean"
exit 0

//--- rv_decode.f
+incdir+rtl
+incdir+verif
rtl/rv_decode_pkg.sv
rtl/operand_if.sv
rtl/operand_fwd.sv
rtl/insn_decoder.sv
rtl/id_stage_reg.sv
rtl/id_stage.sv
verif/tb_id_stage.sv

//--- verif/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: name, pc, insn, regfile data 0/1, mem stage valid/dst/we/data,
// then expected alu_op, alu_in_0, alu_in_1, br_addr, br_taken, br_flag,
// mem_op, mem_wr_data, dst_addr, gpr_we
typedef struct
{
	string		name;
	logic [31:0]	pc, insn, rd0, rd1;
	logic		mv;
	logic [4:0]	md;
	logic		mw;
	logic [31:0]	mdat;
	alu_op_e	alu;
	logic [31:0]	in0, in1, bra;
	logic		bt, bf;
	mem_op_e	mop;
	logic [31:0]	wd;
	logic [4:0]	dst;
	logic		we;
} vec_t;

vec_t	vecs[$];			// applied in order

task automatic load_vectors();
	vecs = {};
	//////////////////////////////
	// alu, register-register and register-immediate
	vecs.push_back('{"add", 32'h0, 32'h002081B3, 32'hFFFFFFFF, 32'h1, 0, 0, 0, 32'h0,
		ALU_ADD, 32'hFFFFFFFF, 32'h1, 32'h0, 0, 0, MEM_NOP, 32'h0, 5'd3, 1});
	vecs.push_back('{"sub", 32'h4, 32'h402081B3, 32'hFFFFFFFF, 32'h1, 0, 0, 0, 32'h0,
		ALU_SUB, 32'hFFFFFFFF, 32'h1, 32'h0, 0, 0, MEM_NOP, 32'h0, 5'd3, 1});
	vecs.push_back('{"sra", 32'h8, 32'h4020D233, 32'hFFFFFFFF, 32'h1, 0, 0, 0, 32'h0,
		ALU_SRA, 32'hFFFFFFFF, 32'h1, 32'h0, 0, 0, MEM_NOP, 32'h0, 5'd4, 1});
	vecs.push_back('{"slt", 32'hC, 32'h0020A2B3, 32'hFFFFFFFF, 32'h1, 0, 0, 0, 32'h0,
		ALU_PASS, 32'hFFFFFFFF, 32'h1, 32'h0, 0, 0, MEM_NOP, 32'h0, 5'd5, 1});	// -1 < 1
	vecs.push_back('{"sltu", 32'h10, 32'h0020B2B3, 32'hFFFFFFFF, 32'h1, 0, 0, 0, 32'h0,
		ALU_PASS, 32'hFFFFFFFF, 32'h0, 32'h0, 0, 0, MEM_NOP, 32'h0, 5'd5, 1});
	vecs.push_back('{"addi", 32'h14, 32'hFFB08313, 32'h10, 32'h1, 0, 0, 0, 32'h0,
		ALU_ADD, 32'h10, 32'hFFFFFFFB, 32'h0, 0, 0, MEM_NOP, 32'h0, 5'd6, 1});
	vecs.push_back('{"srai", 32'h18, 32'h4030D393, 32'h80, 32'h1, 0, 0, 0, 32'h0,
		ALU_SRA, 32'h80, 32'h3, 32'h0, 0, 0, MEM_NOP, 32'h0, 5'd7, 1});
	//////////////////////////////
	// control transfers
	vecs.push_back('{"blt", 32'h100, 32'h0020C863, 32'hFFFFFFFF, 32'h1, 0, 0, 0, 32'h0,
		ALU_NOP, 32'hFFFFFFFF, 32'h1, 32'h110, 1, 1, MEM_NOP, 32'h0, 5'd16, 0});
	vecs.push_back('{"bltu", 32'h100, 32'h0020E863, 32'hFFFFFFFF, 32'h1, 0, 0, 0, 32'h0,
		ALU_NOP, 32'hFFFFFFFF, 32'h1, 32'h110, 0, 1, MEM_NOP, 32'h0, 5'd16, 0});
	vecs.push_back('{"jal", 32'h200, 32'h008000EF, 32'h0, 32'h1, 0, 0, 0, 32'h0,
		ALU_PASS, 32'h0, 32'h204, 32'h208, 1, 1, MEM_NOP, 32'h0, 5'd1, 1});
	vecs.push_back('{"jalr", 32'h300, 32'h004100E7, 32'h1001, 32'h1, 0, 0, 0, 32'h0,
		ALU_PASS, 32'h1001, 32'h304, 32'h1004, 1, 1, MEM_NOP, 32'h0, 5'd1, 1});
	vecs.push_back('{"lui", 32'h304, 32'h12345437, 32'h5, 32'h6, 0, 0, 0, 32'h0,
		ALU_PASS, 32'h0, 32'h12345000, 32'h0, 0, 0, MEM_NOP, 32'h0, 5'd8, 1});
	vecs.push_back('{"auipc", 32'h400, 32'h00001497, 32'h5, 32'h6, 0, 0, 0, 32'h0,
		ALU_ADD, 32'h400, 32'h1000, 32'h0, 0, 0, MEM_NOP, 32'h0, 5'd9, 1});
	//////////////////////////////
	// memory
	vecs.push_back('{"lw", 32'h404, 32'hFFC0A503, 32'h2000, 32'h7, 0, 0, 0, 32'h0,
		ALU_ADD, 32'h2000, 32'hFFFFFFFC, 32'h0, 0, 0, MEM_LW, 32'h0, 5'd10, 1});
	vecs.push_back('{"lbu", 32'h408, 32'h0010C583, 32'h2000, 32'h2000, 0, 0, 0, 32'h0,
		ALU_ADD, 32'h2000, 32'h1, 32'h0, 0, 0, MEM_LBU, 32'h0, 5'd11, 1});
	vecs.push_back('{"sw", 32'h40C, 32'h0020A423, 32'h2000, 32'h5A5A1234, 0, 0, 0, 32'h0,
		ALU_ADD, 32'h2000, 32'h8, 32'h0, 0, 0, MEM_SW, 32'h5A5A1234, 5'd8, 0});
	vecs.push_back('{"sh", 32'h410, 32'hFE209F23, 32'h2000, 32'h0000BEEF, 0, 0, 0, 32'h0,
		ALU_ADD, 32'h2000, 32'hFFFFFFFE, 32'h0, 0, 0, MEM_SH, 32'h0000BEEF, 5'd30, 0});
	//////////////////////////////
	// mem stage bypass and an unknown opcode
	vecs.push_back('{"add_memfwd", 32'h414, 32'h002081B3, 32'h11, 32'h22, 1, 5'd1, 1,
		32'hCAFE0000, ALU_ADD, 32'hCAFE0000, 32'h22, 32'h0, 0, 0, MEM_NOP, 32'h0, 5'd3, 1});
	vecs.push_back('{"fence", 32'h418, 32'h0000000F, 32'h33, 32'h44, 0, 0, 0, 32'h0,
		ALU_NOP, 32'h33, 32'h44, 32'h0, 0, 0, MEM_NOP, 32'h0, 5'd0, 0});
endtask

`endif

//--- verif/tb_id_stage.sv
`timescale 1ns/10ps

module tb_id_stage import rv_decode_pkg::*;
();

	localparam int TMO = 50;		// cycles per wait

	logic clk = 1'b0, rst_n, if_valid, id_ready, mem_valid, mem_we;
	logic [31:0] pc, insn, rd0, rd1, exe_data, mem_data;
	logic [4:0] mem_dst;
	logic if_ready_o, id_valid_o, br_taken_o, br_flag_o, gpr_we_o;
	logic [4:0] rd_addr_0, rd_addr_1, dst_addr_o;
	alu_op_e alu_op_o;
	mem_op_e mem_op_o;
	logic [31:0] alu_in_0_o, alu_in_1_o, br_addr_o, mem_wr_data_o;
	int mism = 0, fails = 0;		// wrong values and other failures
	logic [31:0] rng = 32'h73fcb6af;

	`include "tb_vectors.svh"

	id_stage i_dut (.clk_i(clk), .rst_n_i(rst_n), .if_valid_i(if_valid), .if_ready_o(if_ready_o),
		.if_pc_i(pc), .if_insn_i(insn), .gpr_rd_addr_0_o(rd_addr_0),
		.gpr_rd_addr_1_o(rd_addr_1), .gpr_rd_data_0_i(rd0), .gpr_rd_data_1_i(rd1),
		.exe_fwd_data_i(exe_data), .mem_stage_valid_i(mem_valid), .mem_stage_dst_i(mem_dst),
		.mem_stage_we_i(mem_we), .mem_fwd_data_i(mem_data), .id_valid_o(id_valid_o),
		.id_ready_i(id_ready), .alu_op_o(alu_op_o), .alu_in_0_o(alu_in_0_o),
		.alu_in_1_o(alu_in_1_o), .br_addr_o(br_addr_o), .br_taken_o(br_taken_o),
		.br_flag_o(br_flag_o), .mem_op_o(mem_op_o), .mem_wr_data_o(mem_wr_data_o),
		.dst_addr_o(dst_addr_o), .gpr_we_o(gpr_we_o));

	always #10 clk = ~clk;			// 20 ns period

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d other failures", mism, fails);
		if (mism == 0 && fails == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	task automatic check_field(input string name, input string fld, input logic [31:0] exp,
		input logic [31:0] act);
		assert (exp === act) else
		begin
			$display("Mismatch %s %s: expected %h, actual %h", name, fld, exp, act);
			mism++;
		end
	endtask

	task automatic check_outputs(input vec_t v);		// all fields of one result
		check_field(v.name, "alu_op", 32'(v.alu), 32'(alu_op_o));
		check_field(v.name, "alu_in_0", v.in0, alu_in_0_o);
		check_field(v.name, "alu_in_1", v.in1, alu_in_1_o);
		check_field(v.name, "br_addr", v.bra, br_addr_o);
		check_field(v.name, "br_taken", 32'(v.bt), 32'(br_taken_o));
		check_field(v.name, "br_flag", 32'(v.bf), 32'(br_flag_o));
		check_field(v.name, "mem_op", 32'(v.mop), 32'(mem_op_o));
		check_field(v.name, "mem_wr_data", v.wd, mem_wr_data_o);
		check_field(v.name, "dst_addr", 32'(v.dst), 32'(dst_addr_o));
		check_field(v.name, "gpr_we", 32'(v.we), 32'(gpr_we_o));
	endtask

	task automatic drive_vec(input vec_t v);
		if_valid = 1'b1;
		pc = v.pc;
		insn = v.insn;
		rd0 = v.rd0;
		rd1 = v.rd1;
		mem_valid = v.mv;
		mem_dst = v.md;
		mem_we = v.mw;
		mem_data = v.mdat;
	endtask

	task automatic wait_accept(input string name);		// leaves 2 ns after accepting edge
		int n;
		n = 0;
		@(negedge clk);
		while (!if_ready_o && n <= TMO)
		begin
			n++;
			@(negedge clk);
		end
		if (!if_ready_o)
		begin
			$display("timeout: %s never accepted by the stage", name);
			fails++;
		end
		@(posedge clk);
		#2 if_valid = 1'b0;
		mem_valid = 1'b0;
	endtask

	task automatic wait_valid(input string name);
		int n;
		n = 0;
		@(negedge clk);
		while (!id_valid_o && n <= TMO)
		begin
			n++;
			@(negedge clk);
		end
		if (!id_valid_o)
		begin
			$display("timeout: %s never reached the outputs", name);
			fails++;
		end
		else
		begin
			assert (n == 0) else
			begin
				$display("%s took %0d extra cycles to appear", name, n);
				fails++;
			end
		end
	endtask

	task automatic drain();				// one cycle of id_ready
		@(posedge clk);
		#2 id_ready = 1'b1;
		@(posedge clk);
		#2 id_ready = 1'b0;
	endtask

	// one directed insn against a chosen expected alu_in_0
	task automatic run_directed(input string name, input logic [31:0] i_w,
		input logic [4:0] md, input logic mw, input logic [31:0] exp0);
		vec_t v;
		v = '{name, 32'h500, i_w, 32'hAAAA0003, 32'h7, 1, md, mw, 32'hBBBB0002,
			ALU_NOP, 32'h0, 32'h0, 32'h0, 0, 0, MEM_NOP, 32'h0, 5'd0, 0};
		@(posedge clk);
		#2 id_ready = 1'b1;				// drain and refill together
		drive_vec(v);
		wait_accept(name);
		wait_valid(name);
		check_field(name, "alu_in_0", exp0, alu_in_0_o);
		drain();
	endtask

	initial
	begin
		#2_000_000;
		$display("timeout: global run limit reached");
		fails++;
		finish_run();
	end

	initial
	begin
		int k;
		int got;
		logic stalled;
		vec_t snap;
		rst_n = 1'b0;
		if_valid = 1'b0;
		id_ready = 1'b0;
		pc = '0;
		insn = '0;
		rd0 = '0;
		rd1 = '0;
		exe_data = 32'hCCCC0001;			// visible only via a held writer
		mem_valid = 1'b0;
		mem_dst = '0;
		mem_we = 1'b0;
		mem_data = '0;
		load_vectors();
		repeat (16) @(posedge clk);
		#2 rst_n = 1'b1;
		@(negedge clk);
		assert (!id_valid_o && if_ready_o) else
		begin
			$display("handshake not idle after reset");
			fails++;
		end

		//////////////////////////////
		// table with one insn at a time
		foreach (vecs[i])
		begin
			@(posedge clk);
			#2 drive_vec(vecs[i]);
			wait_accept(vecs[i].name);
			wait_valid(vecs[i].name);
			check_outputs(vecs[i]);
			drain();
		end

		//////////////////////////////
		// forwarding priority with x5 written by held addi
		@(posedge clk);
		#2 drive_vec('{"addi_x5", 32'h4FC, 32'h00108293, 32'h1, 32'h0, 0, 0, 0, 32'h0,
			ALU_NOP, 32'h0, 32'h0, 32'h0, 0, 0, MEM_NOP, 32'h0, 5'd0, 0});
		wait_accept("addi_x5");
		wait_valid("addi_x5");
		run_directed("fwd_exe", 32'h00228333, 5'd5, 1'b1, 32'hCCCC0001);
		run_directed("fwd_mem", 32'h00228333, 5'd5, 1'b1, 32'hBBBB0002);
		run_directed("fwd_gpr", 32'h00228333, 5'd5, 1'b0, 32'hAAAA0003);

		//////////////////////////////
		// load-use with lw x6 then add x7,x6,x2
		@(posedge clk);
		#2 drive_vec('{"lw_x6", 32'h600, 32'h0000A303, 32'h3000, 32'h0, 0, 0, 0, 32'h0,
			ALU_NOP, 32'h0, 32'h0, 32'h0, 0, 0, MEM_NOP, 32'h0, 5'd0, 0});
		wait_accept("lw_x6");
		wait_valid("lw_x6");
		@(posedge clk);
		#2 insn = 32'h002303B3;
		if_valid = 1'b1;
		id_ready = 1'b1;					// load drains at the next edge
		@(negedge clk);
		check_field("add_x7", "gpr_rd_addr_0", 32'd6, 32'(rd_addr_0));
		check_field("add_x7", "gpr_rd_addr_1", 32'd2, 32'(rd_addr_1));
		assert (!if_ready_o) else
		begin
			$display("dependent insn accepted while load still held");
			fails++;
		end
		@(posedge clk);
		#2 mem_valid = 1'b1;				// load result now in mem stage
		mem_dst = 5'd6;
		mem_we = 1'b1;
		mem_data = 32'hD00D0006;
		wait_accept("add_x7");
		wait_valid("add_x7");
		check_field("add_x7", "alu_in_0", 32'hD00D0006, alu_in_0_o);
		drain();

		//////////////////////////////
		// back-pressure with the table streamed under random id_ready
		fork
			foreach (vecs[i])
			begin
				@(posedge clk);
				#2 drive_vec(vecs[i]);
				wait_accept(vecs[i].name);
			end
			begin
				got = 0;
				stalled = 1'b0;
				k = 0;
				while (got < vecs.size() && k <= TMO * vecs.size())
				begin
					@(posedge clk);
					#2 rng = xorshift32(rng);
					id_ready = rng[7];
					@(negedge clk);
					if (stalled)
						check_outputs(snap);		// must not move while stalled
					stalled = 1'b0;
					if (id_valid_o && id_ready)
					begin
						check_outputs(vecs[got]);
						got++;
					end
					else if (id_valid_o)
					begin
						snap = vecs[got];
						snap.name = {vecs[got].name, "_hold"};
						stalled = 1'b1;
					end
					k++;
				end
				if (got < vecs.size())
				begin
					$display("timeout: stream stopped after %0d results", got);
					fails++;
				end
			end
		join
		@(posedge clk);
		#2 id_ready = 1'b1;
		repeat (3)
		begin
			@(negedge clk);
			assert (!id_valid_o) else
			begin
				$display("extra result after the stream ended");
				fails++;
			end
		end
		finish_run();
	end

endmodule
